/* design/isa_pkg.sv */
package isa_pkg;

    // ------------------------------
    // Instruction format
    // ------------------------------

    localparam int INSTR_W = 32;

    // Opcode field sits in the top six bits
    localparam int OPCODE_MSB = 31;
    localparam int OPCODE_LSB = 26;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_HALT  = 6'h3f
    } opcode_e;

    // Full halt instruction as placed in program memory
    localparam logic [INSTR_W-1:0] HALT_WORD = '1;

    // ------------------------------
    // Fetch control
    // ------------------------------

    typedef enum logic [1:0] {
        FS_IDLE,
        FS_RUN,
        FS_HALTED
    } fetch_state_e;

endpackage

/* design/bus_pkg.sv */
package bus_pkg;

    // ------------------------------
    // APB widths
    // ------------------------------

    localparam int APB_ADDR_W = 16;
    localparam int APB_DATA_W = 32;

    // ------------------------------
    // Register map
    // ------------------------------

    // Program memory occupies every offset below this one
    localparam logic [APB_ADDR_W-1:0] MEM_WINDOW_END = 16'h8000;

    localparam logic [APB_ADDR_W-1:0] CTRL_OFFSET   = 16'h8000;
    localparam logic [APB_ADDR_W-1:0] STATUS_OFFSET = 16'h8004;

    // Bit positions inside the control and status words
    localparam int CTRL_RUN_BIT      = 0;
    localparam int STATUS_HALTED_BIT = 0;
    localparam int STATUS_RUN_BIT    = 1;

    typedef enum logic [1:0] {
        AS_IDLE,
        AS_ACCESS,
        AS_READ_WAIT
    } apb_state_e;

endpackage

/* design/pc_unit.sv */
module pc_unit #(
    parameter int ADDR_W = 9
) (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_run,
    input  logic              i_start,
    input  logic              i_branch_taken,
    input  logic [ADDR_W-1:0] i_branch_target,
    input  logic              i_jump,
    input  logic [ADDR_W-1:0] i_jump_target,
    input  logic              i_stall,
    input  logic              i_mem_halt,
    output logic [ADDR_W-1:0] o_fetch_addr,
    output logic [ADDR_W-1:0] o_pc,
    output logic              o_valid,
    output logic              o_halted
);
    import isa_pkg::*;

    fetch_state_e      state_q;
    fetch_state_e      state_d;
    logic [ADDR_W-1:0] pc_q;
    logic              valid_q;
    logic              active;

    // Fetch moves only while running and the current word is not a halt
    assign active = (state_q == FS_RUN) && i_run && !i_mem_halt;

    // ------------------------------
    // Next fetch address
    // ------------------------------

    always_comb begin
        if (i_start) begin
            o_fetch_addr = '0;
        end else if (!active) begin
            o_fetch_addr = pc_q;
        end else if (i_branch_taken) begin
            o_fetch_addr = i_branch_target;
        end else if (i_jump) begin
            o_fetch_addr = i_jump_target;
        end else if (i_stall) begin
            o_fetch_addr = pc_q;
        end else begin
            // Wraps at the memory depth
            o_fetch_addr = pc_q + 1'b1;
        end
    end

    // ------------------------------
    // Fetch state
    // ------------------------------

    always_comb begin
        state_d = state_q;
        if (i_start) begin
            state_d = FS_RUN;
        end else if (!i_run) begin
            state_d = FS_IDLE;
        end else if ((state_q == FS_RUN) && i_mem_halt) begin
            state_d = FS_HALTED;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            state_q <= FS_IDLE;
            pc_q    <= '0;
            valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            pc_q    <= o_fetch_addr;
            valid_q <= i_start || active;
        end
    end

    assign o_pc     = pc_q;
    assign o_valid  = valid_q && !i_mem_halt;
    // Halt shows in the same cycle the halt word leaves the memory
    assign o_halted = (state_q == FS_HALTED) || ((state_q == FS_RUN) && i_mem_halt);

endmodule

/* design/apb_prog_loader.sv */
module apb_prog_loader #(
    parameter int ADDR_W = 9
) (
    input  logic                           i_clk,
    input  logic                           i_rst,
    input  logic                           i_psel,
    input  logic                           i_penable,
    input  logic                           i_pwrite,
    input  logic [bus_pkg::APB_ADDR_W-1:0] i_paddr,
    input  logic [bus_pkg::APB_DATA_W-1:0] i_pwdata,
    input  logic                           i_halted,
    input  logic [isa_pkg::INSTR_W-1:0]    i_load_rdata,
    output logic [bus_pkg::APB_DATA_W-1:0] o_prdata,
    output logic                           o_pready,
    output logic                           o_pslverr,
    output logic                           o_run,
    output logic                           o_start,
    output logic [ADDR_W-1:0]              o_load_addr,
    output logic [isa_pkg::INSTR_W-1:0]    o_load_wdata,
    output logic                           o_load_we
);
    import bus_pkg::*;

    apb_state_e state_q;
    apb_state_e state_d;
    logic       run_q;
    logic       start_q;
    logic       access;
    logic       is_mem;
    logic       is_ctrl;
    logic       is_status;
    logic       mem_read;

    // ------------------------------
    // Address decode
    // ------------------------------

    assign access    = (state_q == AS_ACCESS) && i_psel && i_penable;
    assign is_mem    = i_paddr < MEM_WINDOW_END;
    assign is_ctrl   = i_paddr == CTRL_OFFSET;
    assign is_status = i_paddr == STATUS_OFFSET;
    assign mem_read  = is_mem && !i_pwrite;

    always_comb begin
        state_d = state_q;
        case (state_q)
            AS_IDLE: begin
                if (i_psel && !i_penable) begin
                    state_d = AS_ACCESS;
                end
            end
            AS_ACCESS: begin
                if (!i_psel) begin
                    state_d = AS_IDLE;
                end else if (i_penable) begin
                    // RAM read data shows up one cycle later
                    state_d = mem_read ? AS_READ_WAIT : AS_IDLE;
                end
            end
            AS_READ_WAIT: state_d = AS_IDLE;
            default:      state_d = AS_IDLE;
        endcase
    end

    // ------------------------------
    // APB response
    // ------------------------------

    assign o_pready  = (access && !mem_read) || (state_q == AS_READ_WAIT);
    assign o_pslverr = access && is_mem && i_pwrite && run_q;

    always_comb begin
        o_prdata = '0;
        if (state_q == AS_READ_WAIT) begin
            o_prdata = i_load_rdata;
        end else if (access && !i_pwrite) begin
            if (is_ctrl) begin
                o_prdata[CTRL_RUN_BIT] = run_q;
            end else if (is_status) begin
                o_prdata[STATUS_HALTED_BIT] = i_halted;
                o_prdata[STATUS_RUN_BIT]    = run_q;
            end
        end
    end

    // Program writes are refused while the core fetches
    assign o_load_we    = access && is_mem && i_pwrite && !run_q;
    assign o_load_addr  = i_paddr[ADDR_W+1:2];
    assign o_load_wdata = i_pwdata;

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            state_q <= AS_IDLE;
            run_q   <= 1'b0;
            start_q <= 1'b0;
        end else begin
            state_q <= state_d;
            start_q <= 1'b0;
            if (access && i_pwrite && is_ctrl) begin
                run_q   <= i_pwdata[CTRL_RUN_BIT];
                start_q <= i_pwdata[CTRL_RUN_BIT] && !run_q;
            end
        end
    end

    assign o_run   = run_q;
    assign o_start = start_q;

endmodule

/* design/instr_mem.sv */
module instr_mem #(
    parameter int ADDR_W = 9
) (
    input  logic                        i_clk,
    input  logic [ADDR_W-1:0]           i_fetch_addr,
    input  logic [ADDR_W-1:0]           i_load_addr,
    input  logic [isa_pkg::INSTR_W-1:0] i_load_wdata,
    input  logic                        i_load_we,
    output logic [isa_pkg::INSTR_W-1:0] o_fetch_data,
    output logic                        o_fetch_halt,
    output logic [isa_pkg::INSTR_W-1:0] o_load_rdata
);
    import isa_pkg::*;

    localparam int DEPTH = 2 ** ADDR_W;

    logic [INSTR_W-1:0] mem [DEPTH];
    opcode_e            fetch_op;

    // ------------------------------
    // Fetch port
    // ------------------------------

    always_ff @(posedge i_clk) begin
        o_fetch_data <= mem[i_fetch_addr];
    end

    // ------------------------------
    // Load port
    // ------------------------------

    // Readback in a write cycle returns the old word
    always_ff @(posedge i_clk) begin
        if (i_load_we) begin
            mem[i_load_addr] <= i_load_wdata;
        end
        o_load_rdata <= mem[i_load_addr];
    end

    // Halt decode on the registered fetch word
    assign fetch_op     = opcode_e'(o_fetch_data[OPCODE_MSB:OPCODE_LSB]);
    assign o_fetch_halt = (fetch_op == OP_HALT);

endmodule

/* design/fetch_stage.sv */
module fetch_stage #(
    parameter int ADDR_W = 9
) (
    input  logic                           i_clk,
    input  logic                           i_rst,
    // Processor side
    input  logic                           i_branch_taken,
    input  logic [ADDR_W-1:0]              i_branch_target,
    input  logic                           i_jump,
    input  logic [ADDR_W-1:0]              i_jump_target,
    input  logic                           i_stall,
    output logic [ADDR_W-1:0]              o_pc,
    output logic [isa_pkg::INSTR_W-1:0]    o_instr,
    output logic                           o_valid,
    output logic                           o_halted,
    // APB side
    input  logic                           i_psel,
    input  logic                           i_penable,
    input  logic                           i_pwrite,
    input  logic [bus_pkg::APB_ADDR_W-1:0] i_paddr,
    input  logic [bus_pkg::APB_DATA_W-1:0] i_pwdata,
    output logic [bus_pkg::APB_DATA_W-1:0] o_prdata,
    output logic                           o_pready,
    output logic                           o_pslverr
);
    import isa_pkg::*;

    logic               run;
    logic               start;
    logic               mem_halt;
    logic [ADDR_W-1:0]  fetch_addr;
    logic [ADDR_W-1:0]  load_addr;
    logic [INSTR_W-1:0] load_wdata;
    logic [INSTR_W-1:0] load_rdata;
    logic               load_we;

    pc_unit #(
        .ADDR_W (ADDR_W)
    ) u_pc_unit (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_run           (run),
        .i_start         (start),
        .i_branch_taken  (i_branch_taken),
        .i_branch_target (i_branch_target),
        .i_jump          (i_jump),
        .i_jump_target   (i_jump_target),
        .i_stall         (i_stall),
        .i_mem_halt      (mem_halt),
        .o_fetch_addr    (fetch_addr),
        .o_pc            (o_pc),
        .o_valid         (o_valid),
        .o_halted        (o_halted)
    );

    apb_prog_loader #(
        .ADDR_W (ADDR_W)
    ) u_apb_prog_loader (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_psel       (i_psel),
        .i_penable    (i_penable),
        .i_pwrite     (i_pwrite),
        .i_paddr      (i_paddr),
        .i_pwdata     (i_pwdata),
        .i_halted     (o_halted),
        .i_load_rdata (load_rdata),
        .o_prdata     (o_prdata),
        .o_pready     (o_pready),
        .o_pslverr    (o_pslverr),
        .o_run        (run),
        .o_start      (start),
        .o_load_addr  (load_addr),
        .o_load_wdata (load_wdata),
        .o_load_we    (load_we)
    );

    instr_mem #(
        .ADDR_W (ADDR_W)
    ) u_instr_mem (
        .i_clk        (i_clk),
        .i_fetch_addr (fetch_addr),
        .i_load_addr  (load_addr),
        .i_load_wdata (load_wdata),
        .i_load_we    (load_we),
        .o_fetch_data (o_instr),
        .o_fetch_halt (mem_halt),
        .o_load_rdata (load_rdata)
    );

endmodule

/* verification/fetch_checker.sv */
module fetch_checker #(
    parameter int ADDR_W = 9
) (
    input  logic                           i_clk,
    input  logic                           i_rst,
    input  logic                           i_branch_taken,
    input  logic [ADDR_W-1:0]              i_branch_target,
    input  logic                           i_jump,
    input  logic [ADDR_W-1:0]              i_jump_target,
    input  logic                           i_stall,
    input  logic [ADDR_W-1:0]              i_pc,
    input  logic [isa_pkg::INSTR_W-1:0]    i_instr,
    input  logic                           i_valid,
    input  logic                           i_halted,
    input  logic                           i_psel,
    input  logic                           i_penable,
    input  logic                           i_pwrite,
    input  logic [bus_pkg::APB_ADDR_W-1:0] i_paddr,
    input  logic [bus_pkg::APB_DATA_W-1:0] i_pwdata,
    input  logic [bus_pkg::APB_DATA_W-1:0] i_prdata,
    input  logic                           i_pready,
    input  logic                           i_pslverr,
    output int                             o_check_count,
    output int                             o_error_count
);
    timeunit 1ns;
    timeprecision 1ps;
    import isa_pkg::*;
    import bus_pkg::*;

    localparam int DEPTH = 2 ** ADDR_W;

    logic [INSTR_W-1:0] shadow [DEPTH];
    fetch_state_e       m_state;
    logic [ADDR_W-1:0]  m_pc;
    logic [INSTR_W-1:0] m_instr;
    logic               m_valid_q;
    logic               m_run;
    logic               m_start;
    int                 access_cycles;
    int                 checks = 0;
    int                 errors = 0;

    assign o_check_count = checks;
    assign o_error_count = errors;

    // ------------------------------
    // Reference model
    // ------------------------------

    // Next fetch address by the stage's priority rule
    function automatic logic [ADDR_W-1:0] next_fetch_addr(
        input logic              start,
        input logic              active,
        input logic              branch,
        input logic [ADDR_W-1:0] branch_target,
        input logic              jump,
        input logic [ADDR_W-1:0] jump_target,
        input logic              stall,
        input logic [ADDR_W-1:0] pc
    );
        if (start) begin
            return '0;
        end
        if (!active || (!branch && !jump && stall)) begin
            return pc;
        end
        if (branch) begin
            return branch_target;
        end
        if (jump) begin
            return jump_target;
        end
        // Wraps at the memory depth
        return pc + 1'b1;
    endfunction

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    always @(posedge i_clk) begin : model
        logic              halt_now;
        logic              active;
        logic              exp_halted;
        logic              done;
        logic              is_mem;
        logic [ADDR_W-1:0] word_idx;
        logic [ADDR_W-1:0] next_pc;

        halt_now   = (m_instr[OPCODE_MSB:OPCODE_LSB] === OP_HALT);
        active     = (m_state == FS_RUN) && m_run && !halt_now;
        // Halted while the registered word is a halt and fetch was not stopped
        exp_halted = (m_state != FS_IDLE) && halt_now;
        done       = i_psel && i_penable && i_pready;
        is_mem     = i_paddr < MEM_WINDOW_END;
        word_idx   = ADDR_W'(i_paddr >> 2);

        if (!i_rst) begin
            m_state       = FS_IDLE;
            m_pc          = '0;
            m_valid_q     = 1'b0;
            m_run         = 1'b0;
            m_start       = 1'b0;
            access_cycles = 0;
            m_instr       = shadow[0];
        end else begin
            if (m_run) begin
                compare("o_pc", i_pc, m_pc);
                compare("o_instr", i_instr, m_instr);
                compare("o_valid", i_valid, m_valid_q && !halt_now);
                compare("o_halted", i_halted, exp_halted);
            end

            // APB transfer timing and responses
            if (i_psel && i_penable) begin
                access_cycles++;
            end
            if (done) begin
                checks++;
                if (is_mem && !i_pwrite && access_cycles != 2) begin
                    errors++;
                    $display("memory read at 0x%0h finished after %0d access cycles, not 2",
                             i_paddr, access_cycles);
                end else if (!(is_mem && !i_pwrite) && access_cycles != 1) begin
                    errors++;
                    $display("transfer at 0x%0h took %0d access cycles instead of one",
                             i_paddr, access_cycles);
                end
                if (is_mem && !i_pwrite) begin
                    compare("o_prdata", i_prdata, shadow[word_idx]);
                end
                if (i_paddr == STATUS_OFFSET && !i_pwrite) begin
                    compare("o_prdata", i_prdata, {30'b0, m_run, exp_halted});
                end
                compare("o_pslverr", i_pslverr, is_mem && i_pwrite && m_run);
            end
            if (done || !i_psel) begin
                access_cycles = 0;
            end

            // Fetch step reads the memory before a write on this edge lands
            next_pc = next_fetch_addr(m_start, active, i_branch_taken, i_branch_target,
                                      i_jump, i_jump_target, i_stall, m_pc);
            if (m_start) begin
                m_state = FS_RUN;
            end else if (!m_run) begin
                m_state = FS_IDLE;
            end else if ((m_state == FS_RUN) && halt_now) begin
                m_state = FS_HALTED;
            end
            m_valid_q = m_start || active;
            m_instr   = shadow[next_pc];
            m_pc      = next_pc;

            // Control and memory side effects of the finished transfer
            m_start = 1'b0;
            if (done && i_pwrite && i_paddr == CTRL_OFFSET) begin
                m_start = i_pwdata[0] && !m_run;
                m_run   = i_pwdata[0];
            end
            if (done && i_pwrite && is_mem && !i_pslverr) begin
                shadow[word_idx] = i_pwdata;
            end
        end
    end

endmodule

/* verification/fetch_tb.sv */
module fetch_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import isa_pkg::*;
    import bus_pkg::*;

    localparam int ADDR_W        = 6;
    localparam int NUM_WORDS     = 2 ** ADDR_W;
    localparam int RUN_CYCLES    = 80;
    localparam int RAND_CYCLES   = 300;
    localparam int HALT_ADDR     = 20;
    localparam int PROTECT_ADDR  = 5;
    localparam int NUM_TESTS     = 6;
    localparam int NUM_TRANSFERS = 2 * NUM_WORDS + 12;
    // Twice the worst case of five cycles per transfer
    localparam int TIMEOUT_CYCLES =
        2 * (8 + 5 * NUM_TRANSFERS + RUN_CYCLES + RAND_CYCLES + 2 * HALT_ADDR + 50);
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic                  clk;
    logic                  rst;
    logic                  branch_taken;
    logic [ADDR_W-1:0]     branch_target;
    logic                  jump;
    logic [ADDR_W-1:0]     jump_target;
    logic                  stall;
    logic [ADDR_W-1:0]     pc;
    logic [INSTR_W-1:0]    instr;
    logic                  valid;
    logic                  halted;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
    int                    check_count;
    int                    error_count;
    int                    err_base = 0;
    int                    tests_passed = 0;
    int                    cycle_count = 0;
    logic [31:0]           lfsr_state = 32'hf7a7_d498;

    fetch_stage #(
        .ADDR_W (ADDR_W)
    ) u_fetch_stage (
        .i_clk (clk), .i_rst (rst),
        .i_branch_taken (branch_taken), .i_branch_target (branch_target),
        .i_jump (jump), .i_jump_target (jump_target), .i_stall (stall),
        .o_pc (pc), .o_instr (instr), .o_valid (valid), .o_halted (halted),
        .i_psel (psel), .i_penable (penable), .i_pwrite (pwrite),
        .i_paddr (paddr), .i_pwdata (pwdata),
        .o_prdata (prdata), .o_pready (pready), .o_pslverr (pslverr)
    );

    fetch_checker #(
        .ADDR_W (ADDR_W)
    ) u_checker (
        .i_clk (clk), .i_rst (rst),
        .i_branch_taken (branch_taken), .i_branch_target (branch_target),
        .i_jump (jump), .i_jump_target (jump_target), .i_stall (stall),
        .i_pc (pc), .i_instr (instr), .i_valid (valid), .i_halted (halted),
        .i_psel (psel), .i_penable (penable), .i_pwrite (pwrite),
        .i_paddr (paddr), .i_pwdata (pwdata),
        .i_prdata (prdata), .i_pready (pready), .i_pslverr (pslverr),
        .o_check_count (check_count), .o_error_count (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles", cycle_count);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ------------------------------
    // Helpers
    // ------------------------------

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    task automatic apb_transfer(
        input logic                  write,
        input logic [APB_ADDR_W-1:0] addr,
        input logic [APB_DATA_W-1:0] data
    );
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        while (!pready) begin
            @(posedge clk);
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data);
        apb_transfer(1'b1, addr, data);
    endtask

    task automatic apb_read(input logic [APB_ADDR_W-1:0] addr);
        apb_transfer(1'b0, addr, '0);
    endtask

    task automatic report_test(input int num, input string name);
        int errs;
        errs = error_count - err_base;
        if (errs == 0) begin
            tests_passed++;
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errs);
        end
        err_base = error_count;
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------

    initial begin : stimulus
        logic [INSTR_W-1:0] word;

        rst           = 1'b0;
        branch_taken  = 1'b0;
        branch_target = '0;
        jump          = 1'b0;
        jump_target   = '0;
        stall         = 1'b0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        for (int i = 0; i < NUM_WORDS; i++) begin
            word = rand_bits(32);
            // No halt opcode inside the random program
            if (word[OPCODE_MSB:OPCODE_LSB] == OP_HALT) begin
                word[OPCODE_LSB] = 1'b0;
            end
            apb_write(APB_ADDR_W'(i * 4), word);
        end
        for (int i = 0; i < NUM_WORDS; i++) begin
            apb_read(APB_ADDR_W'(i * 4));
        end
        report_test(1, "program load and readback");

        apb_write(CTRL_OFFSET, 32'h1);
        repeat (RUN_CYCLES) @(negedge clk);
        report_test(2, "sequential fetch");

        // Branch wins over a jump in the same cycle
        @(negedge clk);
        branch_taken  = 1'b1;
        branch_target = ADDR_W'(rand_bits(ADDR_W));
        jump          = 1'b1;
        jump_target   = ADDR_W'(rand_bits(ADDR_W));
        @(negedge clk);
        branch_taken = 1'b0;
        jump_target  = ADDR_W'(rand_bits(ADDR_W));
        @(negedge clk);
        jump = 1'b0;
        repeat (4) @(negedge clk);
        report_test(3, "branch and jump redirect");

        repeat (RAND_CYCLES) begin
            @(negedge clk);
            stall         = (rand_bits(2) == 0);
            branch_taken  = (rand_bits(3) == 0);
            branch_target = ADDR_W'(rand_bits(ADDR_W));
            jump          = (rand_bits(3) == 0);
            jump_target   = ADDR_W'(rand_bits(ADDR_W));
        end
        @(negedge clk);
        stall        = 1'b0;
        branch_taken = 1'b0;
        jump         = 1'b0;
        report_test(4, "random stall, branch and jump");

        apb_write(CTRL_OFFSET, 32'h0);
        apb_write(APB_ADDR_W'(HALT_ADDR * 4), HALT_WORD);
        apb_write(CTRL_OFFSET, 32'h1);
        @(posedge clk);
        while (!halted) begin
            @(posedge clk);
        end
        repeat (4) @(negedge clk);
        apb_read(STATUS_OFFSET);
        apb_write(CTRL_OFFSET, 32'h0);
        apb_write(CTRL_OFFSET, 32'h1);
        repeat (HALT_ADDR / 2) @(negedge clk);
        report_test(5, "halt and restart");

        apb_write(APB_ADDR_W'(PROTECT_ADDR * 4), rand_bits(32));
        apb_write(CTRL_OFFSET, 32'h0);
        apb_read(APB_ADDR_W'(PROTECT_ADDR * 4));
        report_test(6, "memory write refused while running");

        repeat (2) @(negedge clk);
        $display("summary: %0d of %0d tests ok, %0d checks, %0d errors",
                 tests_passed, NUM_TESTS, check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* build.f */
design/isa_pkg.sv
design/bus_pkg.sv
design/pc_unit.sv
design/apb_prog_loader.sv
design/instr_mem.sv
design/fetch_stage.sv
verification/fetch_checker.sv
verification/fetch_tb.sv

/* Bender.yml */
package:
  name: fetch_stage

sources:
  - files:
      - design/isa_pkg.sv
      - design/bus_pkg.sv
      - design/pc_unit.sv
      - design/apb_prog_loader.sv
      - design/instr_mem.sv
      - design/fetch_stage.sv
  - target: test
    files:
      - verification/fetch_checker.sv
      - verification/fetch_tb.sv
